// ==== host_rd_pkg.sv ====
// host read bridge package with line geometry, bridge limits and shared vector types
package host_rd_pkg;

    // =========================================================================
    // line and page geometry
    // =========================================================================

    // host byte addresses are 48 bits wide, the bridge only ever moves whole lines
    localparam int byte_addr_bits = 48;
    localparam int line_bytes = 64;
    // PCIe read requests must not cross this boundary
    localparam int page_bytes = 4096;
    localparam int lines_per_page = page_bytes / line_bytes;

    // =========================================================================
    // bridge limits
    // =========================================================================

    // largest read TLP, in lines
    localparam int max_payload_lines = 4;
    // reorder slots, one per outstanding line
    localparam int rob_depth = 16;
    localparam int max_burst_lines = 16;
    // accepted AFU requests whose data has not fully returned
    localparam int rsp_fifo_depth = 4;

    // =========================================================================
    // shared vector types
    // =========================================================================

    typedef logic [byte_addr_bits-$clog2(line_bytes)-1:0] line_addr_t;
    // burst and TLP lengths are both carried as lines minus one
    typedef logic [$clog2(max_burst_lines)-1:0] burst_len_t;
    typedef logic [$clog2(max_payload_lines)-1:0] tlp_len_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_slot_t;
    // one extra bit so that a completely free buffer can be counted
    typedef logic [$clog2(rob_depth+1)-1:0] rob_count_t;
    typedef logic [3:0] rd_id_t;
    // one line of payload, narrowed to 64 bits in this model
    typedef logic [63:0] line_data_t;

    typedef enum logic [0:0] {
        split_idle,
        split_issue
    } split_state_t;

endpackage

// ==== host_rd_splitter.sv ====
// burst splitter that cuts AFU read bursts into page-safe read TLPs and reserves reorder slots
module host_rd_splitter
(
    input  logic                     clk,
    input  logic                     reset,

    // AFU read requests
    input  logic                     req_valid,
    output logic                     req_ready,
    input  host_rd_pkg::line_addr_t  req_addr,
    input  host_rd_pkg::burst_len_t  req_len,
    input  host_rd_pkg::rd_id_t      req_id,

    // slot reservation in the reorder buffer
    input  host_rd_pkg::rob_count_t  free_count,
    input  host_rd_pkg::rob_slot_t   alloc_slot,
    output logic                     alloc,
    output host_rd_pkg::rob_count_t  alloc_lines,

    // request record for the response sequencer
    input  logic                     rec_full,
    output logic                     rec_push,
    output host_rd_pkg::rd_id_t      rec_id,
    output host_rd_pkg::burst_len_t  rec_len,

    // read TLP strobe toward the host
    output logic                     tlp_valid,
    output host_rd_pkg::line_addr_t  tlp_addr,
    output host_rd_pkg::tlp_len_t    tlp_len,
    output host_rd_pkg::rob_slot_t   tlp_tag
);

    host_rd_pkg::split_state_t state;
    host_rd_pkg::split_state_t state_n;

    // address of the next line to request and lines still to be requested
    host_rd_pkg::line_addr_t cur_addr;
    host_rd_pkg::rob_count_t left;

    logic                    ready_q;
    logic                    accept;
    logic                    issue;
    logic [6:0]              page_room;
    host_rd_pkg::rob_count_t chunk;

    assign req_ready = ready_q;
    assign accept = req_valid && ready_q;

    // =========================================================================
    // chunk sizing
    // =========================================================================

    // lines from the current address up to the end of its 4 KB page, 1 to 64
    assign page_room = 7'(host_rd_pkg::lines_per_page)
                     - {1'b0, cur_addr[$clog2(host_rd_pkg::lines_per_page)-1:0]};

    always_comb
    begin
        // start from the TLP payload limit and shrink to the burst tail or page end
        chunk = host_rd_pkg::rob_count_t'(host_rd_pkg::max_payload_lines);
        if (left < chunk)
        begin
            chunk = left;
        end
        if (page_room < {2'b00, chunk})
        begin
            chunk = host_rd_pkg::rob_count_t'(page_room);
        end
    end

    // a chunk goes out only once every one of its lines has a slot to land in
    assign issue = (state == host_rd_pkg::split_issue) && (free_count >= chunk);

    assign tlp_valid = issue;
    assign tlp_addr = cur_addr;
    assign tlp_len = host_rd_pkg::tlp_len_t'(chunk - 1'b1);
    assign tlp_tag = alloc_slot;
    assign alloc = issue;
    assign alloc_lines = chunk;

    // the sequencer learns about the request as soon as it is taken
    assign rec_push = accept;
    assign rec_id = req_id;
    assign rec_len = req_len;

    // =========================================================================
    // state machine
    // =========================================================================

    always_comb
    begin
        state_n = state;
        if (accept)
        begin
            state_n = host_rd_pkg::split_issue;
        end
        else if (issue && (left == chunk))
        begin
            // last chunk of the burst
            state_n = host_rd_pkg::split_idle;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= host_rd_pkg::split_idle;
            ready_q <= 1'b0;
        end
        else
        begin
            state <= state_n;
            // rec_full can only rise through a push, and a push leaves idle anyway
            ready_q <= (state_n == host_rd_pkg::split_idle) && !rec_full;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_addr <= req_addr;
            left <= host_rd_pkg::rob_count_t'(req_len) + 1'b1;
        end
        else if (issue)
        begin
            cur_addr <= cur_addr + host_rd_pkg::line_addr_t'(chunk);
            left <= left - chunk;
        end
    end

endmodule

// ==== cpl_reorder_buf.sv ====
// reorder buffer that stores out-of-order completion lines by slot and hands them out in order
module cpl_reorder_buf
(
    input  logic                     clk,
    input  logic                     reset,

    // reservation from the splitter
    input  logic                     alloc,
    input  host_rd_pkg::rob_count_t  alloc_lines,
    output host_rd_pkg::rob_count_t  free_count,
    output host_rd_pkg::rob_slot_t   alloc_slot,

    // host completions, one line per strobe
    input  logic                     cpl_valid,
    input  host_rd_pkg::rob_slot_t   cpl_slot,
    input  host_rd_pkg::line_data_t  cpl_data,

    // in-order drain by the sequencer
    input  logic                     pop,
    output logic                     head_valid,
    output host_rd_pkg::line_data_t  head_data
);

    host_rd_pkg::line_data_t data_mem [host_rd_pkg::rob_depth];
    logic [host_rd_pkg::rob_depth-1:0] filled;

    host_rd_pkg::rob_slot_t  alloc_ptr;
    host_rd_pkg::rob_slot_t  head_ptr;
    host_rd_pkg::rob_count_t free_cnt;
    host_rd_pkg::rob_count_t free_nxt;

    assign free_count = free_cnt;
    assign alloc_slot = alloc_ptr;

    // the head line is ready only when its own completion has arrived
    assign head_valid = filled[head_ptr];
    assign head_data = data_mem[head_ptr];

    // =========================================================================
    // slot accounting
    // =========================================================================

    always_comb
    begin
        free_nxt = free_cnt;
        if (alloc)
        begin
            free_nxt = free_nxt - alloc_lines;
        end
        // a popped slot is returned one line at a time
        if (pop)
        begin
            free_nxt = free_nxt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alloc_ptr <= '0;
            head_ptr <= '0;
            free_cnt <= host_rd_pkg::rob_count_t'(host_rd_pkg::rob_depth);
            filled <= '0;
        end
        else
        begin
            free_cnt <= free_nxt;
            // slots are handed out as a ring, so the pointer simply wraps
            if (alloc)
            begin
                alloc_ptr <= alloc_ptr + host_rd_pkg::rob_slot_t'(alloc_lines);
            end
            if (pop)
            begin
                filled[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
            // a completion never targets the slot being popped, it is already full
            if (cpl_valid)
            begin
                filled[cpl_slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpl_valid)
        begin
            data_mem[cpl_slot] <= cpl_data;
        end
    end

endmodule

// ==== rd_rsp_sequencer.sv ====
// response sequencer that drains the reorder buffer in order and tags beats with id and last
module rd_rsp_sequencer
(
    input  logic                     clk,
    input  logic                     reset,

    // one record per accepted AFU request
    input  logic                     rec_push,
    input  host_rd_pkg::rd_id_t      rec_id,
    input  host_rd_pkg::burst_len_t  rec_len,
    output logic                     rec_full,

    // head of the reorder buffer
    input  logic                     head_valid,
    input  host_rd_pkg::line_data_t  head_data,
    output logic                     pop,

    // AFU read responses
    input  logic                     rsp_ready,
    output logic                     rsp_valid,
    output host_rd_pkg::line_data_t  rsp_data,
    output host_rd_pkg::rd_id_t      rsp_id,
    output logic                     rsp_last
);

    // the occupancy count needs one more bit than the pointers to show a full FIFO
    typedef logic [$clog2(host_rd_pkg::rsp_fifo_depth)-1:0]   rec_ptr_t;
    typedef logic [$clog2(host_rd_pkg::rsp_fifo_depth+1)-1:0] rec_cnt_t;

    // record FIFO holding the id and length of every request still returning data
    host_rd_pkg::rd_id_t     id_mem  [host_rd_pkg::rsp_fifo_depth];
    host_rd_pkg::burst_len_t len_mem [host_rd_pkg::rsp_fifo_depth];

    rec_ptr_t                wr_ptr;
    rec_ptr_t                rd_ptr;
    rec_cnt_t                rec_cnt;
    logic                    rec_valid;
    logic                    xfer;
    logic                    rec_pop;

    // beats already returned for the oldest request
    host_rd_pkg::burst_len_t beat;

    assign rec_full = (rec_cnt == rec_cnt_t'(host_rd_pkg::rsp_fifo_depth));
    assign rec_valid = (rec_cnt != '0);

    // =========================================================================
    // response channel
    // =========================================================================

    // the head line always belongs to the oldest record, since records are pushed
    // before any of their TLPs are sent
    assign rsp_valid = head_valid && rec_valid;
    assign rsp_data = head_data;
    assign rsp_id = id_mem[rd_ptr];
    assign rsp_last = (beat == len_mem[rd_ptr]);

    assign xfer = rsp_valid && rsp_ready;
    assign pop = xfer;
    assign rec_pop = xfer && rsp_last;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rec_cnt <= '0;
            beat <= '0;
        end
        else
        begin
            if (rec_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (xfer)
            begin
                // the final beat retires the record and restarts the counter
                beat <= rsp_last ? '0 : beat + 1'b1;
            end
            if (rec_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            rec_cnt <= rec_cnt + rec_cnt_t'(rec_push) - rec_cnt_t'(rec_pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rec_push)
        begin
            id_mem[wr_ptr] <= rec_id;
            len_mem[wr_ptr] <= rec_len;
        end
    end

endmodule

// ==== host_rd_top.sv ====
// host memory read bridge top level joining splitter, reorder buffer and response sequencer
module host_rd_top
(
    input  logic                     clk,
    input  logic                     reset,

    // AFU read request channel
    input  logic                     req_valid,
    output logic                     req_ready,
    input  host_rd_pkg::line_addr_t  req_addr,
    input  host_rd_pkg::burst_len_t  req_len,
    input  host_rd_pkg::rd_id_t      req_id,

    // AFU read response channel
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output host_rd_pkg::line_data_t  rsp_data,
    output host_rd_pkg::rd_id_t      rsp_id,
    output logic                     rsp_last,

    // read TLP requests, always accepted by the host
    output logic                     tlp_valid,
    output host_rd_pkg::line_addr_t  tlp_addr,
    output host_rd_pkg::tlp_len_t    tlp_len,
    output host_rd_pkg::rob_slot_t   tlp_tag,

    // completions, one line per strobe and never stalled
    input  logic                     cpl_valid,
    input  host_rd_pkg::rob_slot_t   cpl_slot,
    input  host_rd_pkg::line_data_t  cpl_data
);

    // =========================================================================
    // internal links
    // =========================================================================

    // splitter to reorder buffer
    logic                    alloc;
    host_rd_pkg::rob_count_t alloc_lines;
    host_rd_pkg::rob_count_t free_count;
    host_rd_pkg::rob_slot_t  alloc_slot;

    // splitter to sequencer
    logic                    rec_push;
    host_rd_pkg::rd_id_t     rec_id;
    host_rd_pkg::burst_len_t rec_len;
    logic                    rec_full;

    // sequencer to reorder buffer
    logic                    head_valid;
    host_rd_pkg::line_data_t head_data;
    logic                    pop;

    host_rd_splitter u_splitter
    (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_addr    (req_addr),
        .req_len     (req_len),
        .req_id      (req_id),
        .free_count  (free_count),
        .alloc_slot  (alloc_slot),
        .alloc       (alloc),
        .alloc_lines (alloc_lines),
        .rec_full    (rec_full),
        .rec_push    (rec_push),
        .rec_id      (rec_id),
        .rec_len     (rec_len),
        .tlp_valid   (tlp_valid),
        .tlp_addr    (tlp_addr),
        .tlp_len     (tlp_len),
        .tlp_tag     (tlp_tag)
    );

    cpl_reorder_buf u_rob
    (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .alloc_lines (alloc_lines),
        .free_count  (free_count),
        .alloc_slot  (alloc_slot),
        .cpl_valid   (cpl_valid),
        .cpl_slot    (cpl_slot),
        .cpl_data    (cpl_data),
        .pop         (pop),
        .head_valid  (head_valid),
        .head_data   (head_data)
    );

    rd_rsp_sequencer u_sequencer
    (
        .clk         (clk),
        .reset       (reset),
        .rec_push    (rec_push),
        .rec_id      (rec_id),
        .rec_len     (rec_len),
        .rec_full    (rec_full),
        .head_valid  (head_valid),
        .head_data   (head_data),
        .pop         (pop),
        .rsp_ready   (rsp_ready),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .rsp_id      (rsp_id),
        .rsp_last    (rsp_last)
    );

endmodule

// ==== tb_host_rd.sv ====
// testbench for the host read bridge with a random-order completion model and in-order response checks
module tb_host_rd;

    localparam int clk_period = 100;
    localparam int drive_delay = 10;
    localparam int random_bursts = 40;
    // four directed bursts, two buffer-fill bursts and the random ones
    localparam int num_bursts = random_bursts + 6;
    localparam int watchdog_cycles = num_bursts * host_rd_pkg::max_burst_lines * 40 + 200;

    logic                    clk;
    logic                    reset;
    logic                    req_valid;
    logic                    req_ready;
    host_rd_pkg::line_addr_t req_addr;
    host_rd_pkg::burst_len_t req_len;
    host_rd_pkg::rd_id_t     req_id;
    logic                    rsp_valid;
    logic                    rsp_ready;
    host_rd_pkg::line_data_t rsp_data;
    host_rd_pkg::rd_id_t     rsp_id;
    logic                    rsp_last;
    logic                    tlp_valid;
    host_rd_pkg::line_addr_t tlp_addr;
    host_rd_pkg::tlp_len_t   tlp_len;
    host_rd_pkg::rob_slot_t  tlp_tag;
    logic                    cpl_valid;
    host_rd_pkg::rob_slot_t  cpl_slot;
    host_rd_pkg::line_data_t cpl_data;

    // scoreboard of accepted requests, oldest first
    host_rd_pkg::rd_id_t     exp_id_q [$];
    host_rd_pkg::line_addr_t exp_addr_q [$];
    host_rd_pkg::burst_len_t exp_len_q [$];
    int                      beat;

    // TLP coverage of accepted bursts, one entry per request
    host_rd_pkg::line_addr_t cover_addr_q [$];
    int                      cover_lines_q [$];
    host_rd_pkg::line_addr_t next_tlp_addr;
    int                      tlp_lines_left;
    host_rd_pkg::rob_slot_t  next_tag;
    int                      lines_reserved;
    int                      lines_popped;

    // host model, lines requested but not yet completed
    host_rd_pkg::rob_slot_t  pend_slot_q [$];
    host_rd_pkg::line_addr_t pend_addr_q [$];

    // 0 keeps rsp_ready high, 1 drops it at random, 2 holds it low
    int                      ready_mode;

    // payload seen on a stalled beat, which must still be there a cycle later
    logic                    stalled;
    host_rd_pkg::line_data_t held_data;
    host_rd_pkg::rd_id_t     held_id;
    logic                    held_last;

    host_rd_top u_dut
    (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_len   (req_len),
        .req_id    (req_id),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_id    (rsp_id),
        .rsp_last  (rsp_last),
        .tlp_valid (tlp_valid),
        .tlp_addr  (tlp_addr),
        .tlp_len   (tlp_len),
        .tlp_tag   (tlp_tag),
        .cpl_valid (cpl_valid),
        .cpl_slot  (cpl_slot),
        .cpl_data  (cpl_data)
    );

    // =========================================================================
    // reference model and checks
    // =========================================================================

    // expected line contents, a fixed multiply and rotate mix of the line address
    function automatic host_rd_pkg::line_data_t line_pattern(input host_rd_pkg::line_addr_t addr);
        logic [63:0] mix;
        mix = {22'h0, addr} * 64'h9e37_79b9_7f4a_7c15;
        return mix ^ {mix[34:0], mix[63:35]} ^ 64'hc3a5_0f96_d2e1_4b78;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input host_rd_pkg::line_data_t got,
                              input host_rd_pkg::line_data_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input host_rd_pkg::rd_id_t got,
                            input host_rd_pkg::rd_id_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input host_rd_pkg::line_addr_t got,
                              input host_rd_pkg::line_addr_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_slot(input string name, input host_rd_pkg::rob_slot_t got,
                              input host_rd_pkg::rob_slot_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input host_rd_pkg::tlp_len_t got,
                             input host_rd_pkg::tlp_len_t exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // =========================================================================
    // clock, host completions and AFU ready
    // =========================================================================

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // one completion per cycle, picked at random among the lines still pending
    always @(posedge clk)
    begin
        int pick;
        #drive_delay;
        cpl_valid = 1'b0;
        if (!reset && (pend_slot_q.size() > 0))
        begin
            pick = int'($urandom % pend_slot_q.size());
            cpl_valid = 1'b1;
            cpl_slot = pend_slot_q[pick];
            cpl_data = line_pattern(pend_addr_q[pick]);
            pend_slot_q.delete(pick);
            pend_addr_q.delete(pick);
        end
        case (ready_mode)
            0: rsp_ready = 1'b1;
            1: rsp_ready = (($urandom % 4) != 0);
            default: rsp_ready = 1'b0;
        endcase
    end

    // =========================================================================
    // monitor and compare, sampled mid-cycle where all signals are settled
    // =========================================================================

    always @(negedge clk)
    begin
        int n;
        int exp_n;
        if (!reset)
        begin
            // an accepted request becomes both a scoreboard entry and a span for TLPs to cover
            if (req_valid && req_ready)
            begin
                exp_id_q.push_back(req_id);
                exp_addr_q.push_back(req_addr);
                exp_len_q.push_back(req_len);
                cover_addr_q.push_back(req_addr);
                cover_lines_q.push_back(int'(req_len) + 1);
            end

            if (tlp_valid)
            begin
                n = int'(tlp_len) + 1;
                if (tlp_lines_left == 0)
                begin
                    if (cover_addr_q.size() == 0)
                    begin
                        stop_with_error("a TLP was issued with no accepted burst left to cover");
                    end
                    next_tlp_addr = cover_addr_q.pop_front();
                    tlp_lines_left = cover_lines_q.pop_front();
                end
                check_addr("tlp_addr", tlp_addr, next_tlp_addr);
                check_slot("tlp_tag", tlp_tag, next_tag);
                if (int'(tlp_addr[5:0]) + n > host_rd_pkg::lines_per_page)
                begin
                    stop_with_error("a TLP crosses a 4 KB page boundary");
                end
                if (n > tlp_lines_left)
                begin
                    stop_with_error("a TLP runs past the end of its burst");
                end
                // each TLP takes as many lines as the payload limit, the burst and the page allow
                exp_n = host_rd_pkg::max_payload_lines;
                if (tlp_lines_left < exp_n)
                begin
                    exp_n = tlp_lines_left;
                end
                if (host_rd_pkg::lines_per_page - int'(tlp_addr[5:0]) < exp_n)
                begin
                    exp_n = host_rd_pkg::lines_per_page - int'(tlp_addr[5:0]);
                end
                check_len("tlp_len", tlp_len, host_rd_pkg::tlp_len_t'(exp_n - 1));
                // pops counted so far are the ones the buffer has already seen
                if (lines_reserved + n - lines_popped > host_rd_pkg::rob_depth)
                begin
                    stop_with_error("a TLP was issued without enough free reorder slots");
                end
                for (int k = 0; k < n; k++)
                begin
                    pend_slot_q.push_back(next_tag + host_rd_pkg::rob_slot_t'(k));
                    pend_addr_q.push_back(tlp_addr + host_rd_pkg::line_addr_t'(k));
                end
                next_tlp_addr = next_tlp_addr + host_rd_pkg::line_addr_t'(n);
                next_tag = next_tag + host_rd_pkg::rob_slot_t'(n);
                tlp_lines_left = tlp_lines_left - n;
                lines_reserved = lines_reserved + n;
            end

            // a stalled beat must keep its payload until the AFU takes it
            if (stalled)
            begin
                if (!rsp_valid)
                begin
                    stop_with_error("rsp_valid dropped before the stalled beat was taken");
                end
                check_data("rsp_data", rsp_data, held_data);
                check_id("rsp_id", rsp_id, held_id);
                check_last("rsp_last", rsp_last, held_last);
            end

            if (rsp_valid && rsp_ready)
            begin
                if (exp_id_q.size() == 0)
                begin
                    stop_with_error("a response beat arrived with no outstanding request");
                end
                check_data("rsp_data", rsp_data,
                           line_pattern(exp_addr_q[0] + host_rd_pkg::line_addr_t'(beat)));
                check_id("rsp_id", rsp_id, exp_id_q[0]);
                check_last("rsp_last", rsp_last, beat == int'(exp_len_q[0]));
                lines_popped = lines_popped + 1;
                if (beat == int'(exp_len_q[0]))
                begin
                    void'(exp_id_q.pop_front());
                    void'(exp_addr_q.pop_front());
                    void'(exp_len_q.pop_front());
                    beat = 0;
                end
                else
                begin
                    beat = beat + 1;
                end
            end

            stalled = rsp_valid && !rsp_ready;
            held_data = rsp_data;
            held_id = rsp_id;
            held_last = rsp_last;
        end
    end

    // =========================================================================
    // stimulus
    // =========================================================================

    // presents one burst and holds it until the splitter takes it
    task automatic send_burst(input host_rd_pkg::line_addr_t addr,
                              input host_rd_pkg::burst_len_t len, input host_rd_pkg::rd_id_t id);
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b1;
        req_addr = addr;
        req_len = len;
        req_id = id;
        do
        begin
            @(negedge clk);
        end
        while (!req_ready);
        @(posedge clk);
        #drive_delay;
        req_valid = 1'b0;
    endtask

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_with_error("watchdog expired before every response came back");
    end

    initial
    begin
        host_rd_pkg::line_addr_t addr;
        host_rd_pkg::burst_len_t len;
        void'($urandom(32'h8d48));
        reset = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_len = '0;
        req_id = '0;
        rsp_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl_slot = '0;
        cpl_data = '0;
        ready_mode = 0;
        beat = 0;
        tlp_lines_left = 0;
        next_tlp_addr = '0;
        next_tag = '0;
        lines_reserved = 0;
        lines_popped = 0;
        stalled = 1'b0;
        held_data = '0;
        held_id = '0;
        held_last = 1'b0;
        repeat (4) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        // single line, then a full aligned burst
        send_burst(42'h100, 4'd0, 4'd1);
        send_burst(42'h200, 4'd15, 4'd2);
        // three lines and then one line before a page end
        send_burst(42'h3fd, 4'd15, 4'd3);
        send_burst(42'h7ff, 4'd7, 4'd4);

        // the buffer drains first so that the first stalled burst takes every slot
        while (exp_id_q.size() != 0)
        begin
            @(posedge clk);
        end

        // with the AFU stalled, the second burst runs out of reorder slots
        @(negedge clk);
        ready_mode = 2;
        send_burst(42'h1000, 4'd15, 4'd5);
        send_burst(42'h1010, 4'd15, 4'd6);
        repeat (40) @(negedge clk);
        ready_mode = 0;

        // random bursts with random AFU back-pressure, ids wrap through all values
        @(negedge clk);
        ready_mode = 1;
        for (int i = 0; i < random_bursts; i++)
        begin
            addr = host_rd_pkg::line_addr_t'({$urandom, $urandom});
            len = host_rd_pkg::burst_len_t'($urandom);
            send_burst(addr, len, host_rd_pkg::rd_id_t'(i));
        end
        @(negedge clk);
        ready_mode = 0;

        while (exp_id_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if ((pend_slot_q.size() != 0) || (cover_addr_q.size() != 0) || (tlp_lines_left != 0)
            || (lines_reserved != lines_popped))
        begin
            stop_with_error("lines were still requested or pending after the last response");
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
host_rd_pkg.sv
host_rd_splitter.sv
cpl_reorder_buf.sv
rd_rsp_sequencer.sv
host_rd_top.sv
tb_host_rd.sv

// ==== Makefile ====
RTL = host_rd_pkg.sv host_rd_splitter.sv cpl_reorder_buf.sv rd_rsp_sequencer.sv host_rd_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module host_rd_top $(RTL)

build:
	verilator --binary --timing -Wno-fatal --top-module tb_host_rd -f compile.f -o Vtb_host_rd

sim: build
	-./obj_dir/Vtb_host_rd > sim.log 2>&1
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
